// ==== Makefile ====
TOP   = rv_core_tb
BUILD = build

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) \
		--Mdir $(BUILD) -o sim
	@out="$$(./$(BUILD)/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf $(BUILD)

// ==== hw/alu.sv ====
`timescale 1ns/10ps
`include "rv_cfg.svh"

module alu
  import rv_isa_pkg::*, core_pkg::*;
(
  input  alu_op_e i_op,
  input  word_t   i_a,
  input  word_t   i_b,
  output word_t   o_result
);

  localparam int SHAMT_W = $clog2(`RV_XLEN);

  logic [SHAMT_W-1:0] shamt;
  logic               lt_signed;
  logic               lt_unsigned;

  // shifts only look at the low bits of b
  assign shamt       = i_b[SHAMT_W-1:0];
  assign lt_signed   = $signed(i_a) < $signed(i_b);
  assign lt_unsigned = i_a < i_b;

  always_comb begin
    case (i_op)
      ALU_ADD:    o_result = i_a + i_b;
      ALU_SUB:    o_result = i_a - i_b;
      ALU_SLL:    o_result = i_a << shamt;
      ALU_SLT:    o_result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU:   o_result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:    o_result = i_a ^ i_b;
      ALU_SRL:    o_result = i_a >> shamt;
      // arithmetic shift keeps sign of a
      ALU_SRA:    o_result = word_t'($signed(i_a) >>> shamt);
      ALU_OR:     o_result = i_a | i_b;
      ALU_AND:    o_result = i_a & i_b;
      ALU_PASS_B: o_result = i_b;
      default:    o_result = '0;
    endcase
  end

endmodule

// ==== hw/core_pkg.sv ====
`include "rv_cfg.svh"

package core_pkg;
  import rv_isa_pkg::*;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // nine conditions, so four bits
  typedef enum logic [3:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU,
    BR_JUMP,
    BR_JUMP_REG
  } br_cond_e;

  typedef enum logic {
    A_SRC_REG,
    A_SRC_PC
  } a_src_e;

  typedef enum logic {
    B_SRC_REG,
    B_SRC_IMM
  } b_src_e;

  // decoded control bundle
  typedef struct packed {
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    alu_op_e  alu_op;
    a_src_e   a_src;
    b_src_e   b_src;
    br_cond_e br_cond;
    logic     wr_en;
    // result is pc+4 instead of alu
    logic     link;
    logic     halt;
    logic     illegal;
    word_t    imm;
  } ctrl_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    data;
  } wb_t;

endpackage

// ==== hw/insn_decoder.sv ====
`timescale 1ns/10ps
`include "rv_cfg.svh"

module insn_decoder
  import rv_isa_pkg::*, core_pkg::*;
(
  input  insn_t i_insn,
  output ctrl_t o_ctrl,
  output logic  o_halt,
  output logic  o_illegal
);

  word_t raw;
  word_t imm_i;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;
  ctrl_t ctrl;

  assign raw = i_insn;

  // sign-extended immediates per format
  assign imm_i = {{(`RV_XLEN-12){raw[31]}}, raw[31:20]};
  assign imm_b = {{(`RV_XLEN-13){raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
  assign imm_u = {raw[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};

  always_comb begin
    ctrl         = '0;
    ctrl.rs1     = i_insn.rs1;
    ctrl.rs2     = i_insn.rs2;
    ctrl.rd      = i_insn.rd;
    ctrl.alu_op  = ALU_ADD;
    ctrl.a_src   = A_SRC_REG;
    ctrl.b_src   = B_SRC_REG;
    ctrl.br_cond = BR_NONE;

    case (i_insn.opcode)
      OPC_LUI: begin
        ctrl.wr_en  = 1'b1;
        ctrl.b_src  = B_SRC_IMM;
        ctrl.alu_op = ALU_PASS_B;
        ctrl.imm    = imm_u;
      end
      OPC_AUIPC: begin
        ctrl.wr_en = 1'b1;
        ctrl.a_src = A_SRC_PC;
        ctrl.b_src = B_SRC_IMM;
        ctrl.imm   = imm_u;
      end
      OPC_JAL: begin
        ctrl.wr_en   = 1'b1;
        ctrl.link    = 1'b1;
        ctrl.br_cond = BR_JUMP;
        ctrl.imm     = imm_j;
      end
      OPC_JALR: begin
        ctrl.wr_en   = 1'b1;
        ctrl.link    = 1'b1;
        ctrl.br_cond = BR_JUMP_REG;
        ctrl.imm     = imm_i;
        ctrl.illegal = (i_insn.funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        ctrl.imm = imm_b;
        case (i_insn.funct3)
          F3_BEQ:  ctrl.br_cond = BR_EQ;
          F3_BNE:  ctrl.br_cond = BR_NE;
          F3_BLT:  ctrl.br_cond = BR_LT;
          F3_BGE:  ctrl.br_cond = BR_GE;
          F3_BLTU: ctrl.br_cond = BR_LTU;
          F3_BGEU: ctrl.br_cond = BR_GEU;
          default: ctrl.illegal = 1'b1;
        endcase
      end
      OPC_OP_IMM: begin
        ctrl.wr_en = 1'b1;
        ctrl.b_src = B_SRC_IMM;
        ctrl.imm   = imm_i;
        case (i_insn.funct3)
          F3_ADD:  ctrl.alu_op = ALU_ADD;
          F3_SLT:  ctrl.alu_op = ALU_SLT;
          F3_SLTU: ctrl.alu_op = ALU_SLTU;
          F3_XOR:  ctrl.alu_op = ALU_XOR;
          F3_OR:   ctrl.alu_op = ALU_OR;
          F3_AND:  ctrl.alu_op = ALU_AND;
          F3_SLL: begin
            ctrl.alu_op  = ALU_SLL;
            ctrl.illegal = (i_insn.funct7 != F7_BASE);
          end
          // srli/srai share funct3, funct7 picks
          default: begin
            if (i_insn.funct7 == F7_BASE) begin
              ctrl.alu_op = ALU_SRL;
            end else if (i_insn.funct7 == F7_ALT) begin
              ctrl.alu_op = ALU_SRA;
            end else begin
              ctrl.illegal = 1'b1;
            end
          end
        endcase
      end
      OPC_OP: begin
        ctrl.wr_en = 1'b1;
        if (i_insn.funct7 == F7_BASE) begin
          case (i_insn.funct3)
            F3_ADD:  ctrl.alu_op = ALU_ADD;
            F3_SLL:  ctrl.alu_op = ALU_SLL;
            F3_SLT:  ctrl.alu_op = ALU_SLT;
            F3_SLTU: ctrl.alu_op = ALU_SLTU;
            F3_XOR:  ctrl.alu_op = ALU_XOR;
            F3_SR:   ctrl.alu_op = ALU_SRL;
            F3_OR:   ctrl.alu_op = ALU_OR;
            default: ctrl.alu_op = ALU_AND;
          endcase
        end else if (i_insn.funct7 == F7_ALT && i_insn.funct3 == F3_ADD) begin
          ctrl.alu_op = ALU_SUB;
        end else if (i_insn.funct7 == F7_ALT && i_insn.funct3 == F3_SR) begin
          ctrl.alu_op = ALU_SRA;
        end else begin
          ctrl.illegal = 1'b1;
        end
      end
      OPC_SYSTEM: begin
        // only ecall, all upper bits zero
        if (raw[31:7] == '0) begin
          ctrl.halt = 1'b1;
        end else begin
          ctrl.illegal = 1'b1;
        end
      end
      default: ctrl.illegal = 1'b1;
    endcase

    // illegal falls through to pc+4 with no write
    if (ctrl.illegal) begin
      ctrl.br_cond = BR_NONE;
      ctrl.link    = 1'b0;
    end
    if (ctrl.illegal || ctrl.rd == '0) begin
      ctrl.wr_en = 1'b0;
    end
  end

  assign o_ctrl    = ctrl;
  assign o_halt    = ctrl.halt;
  assign o_illegal = ctrl.illegal;

endmodule

// ==== hw/next_pc_unit.sv ====
`timescale 1ns/10ps
`include "rv_cfg.svh"

module next_pc_unit
  import rv_isa_pkg::*, core_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  ctrl_t i_ctrl,
  input  word_t i_rs1_data,
  input  word_t i_rs2_data,
  output word_t o_pc,
  output word_t o_pc_plus4
);

  word_t pc;
  word_t pc_next;
  word_t br_target;
  word_t jalr_target;
  logic  taken;

  assign o_pc_plus4  = pc + `RV_INSN_BYTES;
  assign br_target   = pc + i_ctrl.imm;
  // jalr drops bit 0 of the sum
  assign jalr_target = (i_rs1_data + i_ctrl.imm) & ~word_t'(1);

  // branch condition on the two register values
  always_comb begin
    case (i_ctrl.br_cond)
      BR_EQ:   taken = (i_rs1_data == i_rs2_data);
      BR_NE:   taken = (i_rs1_data != i_rs2_data);
      BR_LT:   taken = ($signed(i_rs1_data) < $signed(i_rs2_data));
      BR_GE:   taken = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      BR_LTU:  taken = (i_rs1_data < i_rs2_data);
      BR_GEU:  taken = (i_rs1_data >= i_rs2_data);
      BR_JUMP: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (i_ctrl.halt) begin
      pc_next = pc;
    end else if (i_ctrl.br_cond == BR_JUMP_REG) begin
      pc_next = jalr_target;
    end else if (taken) begin
      pc_next = br_target;
    end else begin
      pc_next = o_pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  assign o_pc = pc;

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/10ps
`include "rv_cfg.svh"

module reg_file
  import rv_isa_pkg::*, core_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t i_rs1,
  input  reg_idx_t i_rs2,
  input  wb_t      i_wb,
  output word_t    o_rs1_data,
  output word_t    o_rs2_data
);

  word_t regs [`RV_NUM_REGS];

  // write port, x0 never written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb.valid && (i_wb.rd != '0)) begin
      regs[i_wb.rd] <= i_wb.data;
    end
  end

  // async reads, x0 forced to zero
  always_comb begin
    o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];
  end

endmodule

// ==== hw/rv_cfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data path and address width
`define RV_XLEN 32

// architectural integer registers, x0 included
`define RV_NUM_REGS 32

// first fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

// byte step between sequential instructions
`define RV_INSN_BYTES 4

`endif

// ==== hw/rv_core.sv ====
`timescale 1ns/10ps
`include "rv_cfg.svh"

module rv_core
  import rv_isa_pkg::*, core_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  word_t i_insn,
  output word_t o_pc,
  output wb_t   o_wb,
  output logic  o_halt,
  output logic  o_illegal
);

  ctrl_t ctrl;
  word_t rs1_data;
  word_t rs2_data;
  word_t alu_a;
  word_t alu_b;
  word_t alu_result;
  word_t pc_plus4;
  wb_t   wb;

  insn_decoder i_decoder (
    .i_insn    (insn_t'(i_insn)),
    .o_ctrl    (ctrl),
    .o_halt    (o_halt),
    .o_illegal (o_illegal)
  );

  reg_file i_reg_file (
    .clk        (clk),
    .rst        (rst),
    .i_rs1      (ctrl.rs1),
    .i_rs2      (ctrl.rs2),
    .i_wb       (wb),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  // operand select, auipc uses the pc as a
  assign alu_a = (ctrl.a_src == A_SRC_PC) ? o_pc : rs1_data;
  assign alu_b = (ctrl.b_src == B_SRC_IMM) ? ctrl.imm : rs2_data;

  alu i_alu (
    .i_op     (ctrl.alu_op),
    .i_a      (alu_a),
    .i_b      (alu_b),
    .o_result (alu_result)
  );

  next_pc_unit i_next_pc (
    .clk        (clk),
    .rst        (rst),
    .i_ctrl     (ctrl),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_pc       (o_pc),
    .o_pc_plus4 (pc_plus4)
  );

  // writeback, jal/jalr link pc+4
  assign wb.valid = ctrl.wr_en;
  assign wb.rd    = ctrl.rd;
  assign wb.data  = ctrl.link ? pc_plus4 : alu_result;

  assign o_wb = wb;

endmodule

// ==== hw/rv_isa_pkg.sv ====
`include "rv_cfg.svh"

package rv_isa_pkg;

  // base opcode groups of the kept RV32I subset
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // funct3 for OP and OP_IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct3 for conditional branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // funct7 variants; alt selects SUB and SRA/SRAI
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  typedef logic [4:0] reg_idx_t;

  typedef logic [`RV_XLEN-1:0] word_t;

  // R-type field layout, msb first
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } insn_t;

endpackage

// ==== list.f ====
+incdir+hw
hw/rv_isa_pkg.sv
hw/core_pkg.sv
hw/reg_file.sv
hw/insn_decoder.sv
hw/alu.sv
hw/next_pc_unit.sv
hw/rv_core.sv
verification/rv_core_tb.sv

// ==== verification/rv_core_tb.sv ====
`timescale 1ns/10ps
`include "rv_cfg.svh"

module rv_core_tb
  import rv_isa_pkg::*, core_pkg::*;
();

  logic     clk;
  logic     rst;
  word_t    i_insn;
  word_t    o_pc;
  wb_t      o_wb;
  logic     o_halt;
  logic     o_illegal;

  // expectations for the instruction in flight
  string    test_name;
  logic     chk_en;
  word_t    exp_pc;
  logic     exp_valid;
  reg_idx_t exp_rd;
  word_t    exp_data;
  logic     exp_halt;
  logic     exp_illegal;

  word_t    regs_ref [`RV_NUM_REGS];
  word_t    prog [1024];
  word_t    rng;

  rv_core i_dut (
    .clk       (clk),
    .rst       (rst),
    .i_insn    (i_insn),
    .o_pc      (o_pc),
    .o_wb      (o_wb),
    .o_halt    (o_halt),
    .o_illegal (o_illegal)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic report_mismatch(string what, word_t expected, word_t actual);
    $display("FAILED %s (%s): expected %h, actual %h", test_name, what, expected, actual);
    stop_run();
  endtask

  // outputs are stable mid-cycle, checked at the falling edge
  a_pc: assert property (@(negedge clk) disable iff (rst || !chk_en) o_pc == exp_pc)
    else report_mismatch("pc", exp_pc, o_pc);
  a_valid: assert property (@(negedge clk) disable iff (rst || !chk_en) o_wb.valid == exp_valid)
    else report_mismatch("wb valid", word_t'(exp_valid), word_t'(o_wb.valid));
  a_rd: assert property (@(negedge clk) disable iff (rst || !chk_en)
                         !exp_valid || o_wb.rd == exp_rd)
    else report_mismatch("wb rd", word_t'(exp_rd), word_t'(o_wb.rd));
  a_data: assert property (@(negedge clk) disable iff (rst || !chk_en)
                           !exp_valid || o_wb.data == exp_data)
    else report_mismatch("wb data", exp_data, o_wb.data);
  a_halt: assert property (@(negedge clk) disable iff (rst || !chk_en) o_halt == exp_halt)
    else report_mismatch("halt", word_t'(exp_halt), word_t'(o_halt));
  a_illegal: assert property (@(negedge clk) disable iff (rst || !chk_en)
                              o_illegal == exp_illegal)
    else report_mismatch("illegal", word_t'(exp_illegal), word_t'(o_illegal));

  function automatic word_t xorshift32(word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t r_type(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                   reg_idx_t rs1, reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t i_type(opcode_e opc, logic [2:0] f3, reg_idx_t rd,
                                   reg_idx_t rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t u_type(opcode_e opc, reg_idx_t rd, logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic word_t b_type(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                   logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic word_t j_type(reg_idx_t rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  // RV32I integer semantics, alt picks sub and sra
  function automatic word_t alu_rule(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      F3_ADD:  return alt ? a - b : a + b;
      F3_SLL:  return a << b[4:0];
      F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
      F3_XOR:  return a ^ b;
      F3_SR:   return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      F3_OR:   return a | b;
      default: return a & b;
    endcase
  endfunction

  // place one instruction at the pc, fetch it, then retire it on the next edge
  task automatic step(string name, word_t insn, logic wr, reg_idx_t rd, word_t data,
                      word_t target, logic halt, logic ill);
    prog[exp_pc[11:2]] = insn;
    i_insn = prog[o_pc[11:2]];
    test_name = name;
    exp_valid = wr;
    exp_rd = rd;
    exp_data = data;
    exp_halt = halt;
    exp_illegal = ill;
    chk_en = 1'b1;
    @(posedge clk);
    #1;
    if (wr) begin
      regs_ref[rd] = data;
    end
    exp_pc = target;
  endtask

  task automatic run_rr(string name, logic [2:0] f3, logic alt, reg_idx_t rd,
                        reg_idx_t rs1, reg_idx_t rs2);
    step(name, r_type(alt ? F7_ALT : F7_BASE, f3, rd, rs1, rs2), rd != 5'd0, rd,
         alu_rule(f3, alt, regs_ref[rs1], regs_ref[rs2]), exp_pc + 32'd4, 1'b0, 1'b0);
  endtask

  task automatic run_ri(string name, logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1,
                        logic [11:0] imm);
    logic alt;
    alt = (f3 == F3_SR) && imm[10];
    step(name, i_type(OPC_OP_IMM, f3, rd, rs1, imm), rd != 5'd0, rd,
         alu_rule(f3, alt, regs_ref[rs1], {{20{imm[11]}}, imm}), exp_pc + 32'd4, 1'b0, 1'b0);
  endtask

  // lui then addi, upper part pre-corrected for the signed low part
  task automatic load_reg(reg_idx_t rd, word_t value);
    logic [19:0] upper;
    upper = value[31:12] + {19'd0, value[11]};
    step("lui load", u_type(OPC_LUI, rd, upper), 1'b1, rd, {upper, 12'd0},
         exp_pc + 32'd4, 1'b0, 1'b0);
    run_ri("addi load", F3_ADD, rd, rd, value[11:0]);
  endtask

  task automatic run_branch(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2);
    word_t       a;
    word_t       b;
    logic        taken;
    logic [12:0] off;
    a = regs_ref[rs1];
    b = regs_ref[rs2];
    case (f3)
      F3_BEQ:  taken = (a == b);
      F3_BNE:  taken = (a != b);
      F3_BLT:  taken = ($signed(a) < $signed(b));
      F3_BGE:  taken = ($signed(a) >= $signed(b));
      F3_BLTU: taken = (a < b);
      default: taken = (a >= b);
    endcase
    // equal operands branch backwards
    off = (rs1 == rs2) ? 13'h1ff8 : 13'd24;
    step($sformatf("branch f3=%0d x%0d x%0d", f3, rs1, rs2), b_type(f3, rs1, rs2, off),
         1'b0, 5'd0, '0, taken ? exp_pc + {{19{off[12]}}, off} : exp_pc + 32'd4, 1'b0, 1'b0);
  endtask

  initial begin
    logic [2:0] conds [6];
    conds = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    // nop fill, immediate carries the word address
    for (int i = 0; i < 1024; i++) begin
      prog[i] = i_type(OPC_OP_IMM, F3_ADD, 5'd0, 5'd0, 12'(i));
    end
    for (int i = 0; i < `RV_NUM_REGS; i++) begin
      regs_ref[i] = '0;
    end
    rst = 1'b1;
    chk_en = 1'b0;
    i_insn = prog[0];
    exp_pc = `RV_RESET_PC;
    rng = 32'h96f3;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    step("reset", prog[0], 1'b0, 5'd0, '0, exp_pc + 32'd4, 1'b0, 1'b0);

    for (int r = 0; r < 4; r++) begin
      rng = xorshift32(rng);
      load_reg(5'd1, rng);
      rng = xorshift32(rng);
      load_reg(5'd2, rng);
      for (int f = 0; f < 8; f++) begin
        run_rr($sformatf("rr f3=%0d", f), 3'(f), 1'b0, 5'd3, 5'd1, 5'd2);
      end
      run_rr("sub", F3_ADD, 1'b1, 5'd4, 5'd1, 5'd2);
      run_rr("sra", F3_SR, 1'b1, 5'd4, 5'd1, 5'd2);
      rng = xorshift32(rng);
      for (int f = 0; f < 8; f++) begin
        if (3'(f) == F3_SLL || 3'(f) == F3_SR) begin
          run_ri($sformatf("ri f3=%0d", f), 3'(f), 5'd3, 5'd1, {7'b0, rng[4:0]});
        end else begin
          run_ri($sformatf("ri f3=%0d", f), 3'(f), 5'd3, 5'd1, rng[11:0]);
        end
      end
      run_ri("srai", F3_SR, 5'd4, 5'd1, {F7_ALT, rng[9:5]});
    end

    run_ri("addi to x0", F3_ADD, 5'd0, 5'd1, 12'h7ff);
    run_rr("add x0 x0", F3_ADD, 1'b0, 5'd7, 5'd0, 5'd0);
    step("lui", u_type(OPC_LUI, 5'd10, rng[31:12]), 1'b1, 5'd10, {rng[31:12], 12'd0},
         exp_pc + 32'd4, 1'b0, 1'b0);
    step("auipc", u_type(OPC_AUIPC, 5'd9, 20'h12345), 1'b1, 5'd9, exp_pc + 32'h1234_5000,
         exp_pc + 32'd4, 1'b0, 1'b0);

    // random operands, then a sign split that separates signed and unsigned
    for (int k = 0; k < 2; k++) begin
      if (k == 1) begin
        load_reg(5'd1, 32'h8000_0010);
        load_reg(5'd2, 32'h0000_0020);
      end
      for (int c = 0; c < 6; c++) begin
        run_branch(conds[c], 5'd1, 5'd2);
        run_branch(conds[c], 5'd2, 5'd1);
        run_branch(conds[c], 5'd1, 5'd1);
      end
    end

    step("jal fwd", j_type(5'd8, 21'd40), 1'b1, 5'd8, exp_pc + 32'd4, exp_pc + 32'd40,
         1'b0, 1'b0);
    step("jal back", j_type(5'd8, 21'h1ffff4), 1'b1, 5'd8, exp_pc + 32'd4,
         exp_pc - 32'd12, 1'b0, 1'b0);
    load_reg(5'd5, 32'h0000_0e01);
    step("jalr", i_type(OPC_JALR, 3'b000, 5'd6, 5'd5, 12'h010), 1'b1, 5'd6, exp_pc + 32'd4,
         (regs_ref[5] + 32'h10) & ~32'd1, 1'b0, 1'b0);

    step("illegal", {20'h0badc, 5'd12, 7'b0001011}, 1'b0, 5'd0, '0, exp_pc + 32'd4,
         1'b0, 1'b1);
    for (int k = 0; k < 3; k++) begin
      step("ecall", 32'h0000_0073, 1'b0, 5'd0, '0, exp_pc, 1'b1, 1'b0);
    end
    repeat (3) @(posedge clk);

    $display("PASS: all tests");
    $finish;
  end

endmodule
